/* Makefile */
# Verilator build and run of the FFT pipeline testbench

.PHONY: run clean

run: obj_dir/Vfft_pipe_tb
	@out="$$(./obj_dir/Vfft_pipe_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation finished: PASS$$"

obj_dir/Vfft_pipe_tb: fft_pipe.f $(wildcard logic/*.sv logic/*.svh bench/*.sv)
	verilator --binary --timing -f fft_pipe.f --top-module fft_pipe_tb -Mdir obj_dir

clean:
	rm -rf obj_dir

/* bench/fft_pipe_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fft_settings.svh"

module fft_pipe_tb;

	localparam int OW = `FFT_OUT_W;
	localparam int N_DIRECTED = 6;
	localparam int N_RANDOM = 20;
	localparam int RESET_CYCLES = 10;
	localparam int FRAME_CYCLES = 40;
	localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM) * FRAME_CYCLES + 2 * RESET_CYCLES;

	logic           clk;
	logic           aclr;
	logic           in_valid;
	fft_pkg::cplx_t in_sample;
	logic           in_ready;
	logic           out_valid;
	logic           out_last;
	fft_pkg::cplx_t out_sample;
	logic [15:0]    frames_done;

	int             errors = 0;
	int             checks = 0;
	int             bin_idx = 0;   // position inside the output burst
	logic [31:0]    lcg_state = 32'h7a98_6b95;
	fft_pkg::cplx_t exp_q [$];
	fft_pkg::cplx_t cur_x [4];
	fft_pkg::cplx_t mon_exp;

	// samples as re and im pairs for the six directed frames
	int dir_x [N_DIRECTED][8] = '{
		'{100, 0, 0, 0, 0, 0, 0, 0},
		'{5, -3, 5, -3, 5, -3, 5, -3},
		'{7, 0, -7, 0, 7, 0, -7, 0},
		'{100, 0, 0, -100, -100, 0, 0, 100},
		'{-2048, -2048, -2048, -2048, -2048, -2048, -2048, -2048},
		'{1, 2, 3, -4, -5, 6, 7, 8}
	};
	// expected bins 0 to 3 as re and im pairs
	int dir_y [N_DIRECTED][8] = '{
		'{100, 0, 100, 0, 100, 0, 100, 0},
		'{20, -12, 0, 0, 0, 0, 0, 0},
		'{0, 0, 0, 0, 28, 0, 0, 0},
		'{0, 0, 0, 0, 0, 0, 400, 0},
		'{-8192, -8192, 0, 0, 0, 0, 0, 0},
		'{6, 12, -6, 0, -14, 4, 18, -8}
	};

	fft_pipe u_fft_pipe (
		.clk         (clk),
		.aclr        (aclr),
		.in_valid    (in_valid),
		.in_sample   (in_sample),
		.in_ready    (in_ready),
		.out_valid   (out_valid),
		.out_last    (out_last),
		.out_sample  (out_sample),
		.frames_done (frames_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic fft_pkg::cplx_t make_cplx(input int re, input int im);
		fft_pkg::cplx_t c;
		c.re = OW'(re);
		c.im = OW'(im);
		return c;
	endfunction

	// X[k] = sum of x[n] * (-j)^(n*k)
	function automatic fft_pkg::cplx_t dft_bin(input fft_pkg::cplx_t x [4], input int k);
		int acc_re;
		int acc_im;
		int xr;
		int xi;
		acc_re = 0;
		acc_im = 0;
		for (int n = 0; n < 4; n++)
		begin
			xr = int'(x[n].re);
			xi = int'(x[n].im);
			case ((n * k) % 4)
				0:
				begin
					acc_re += xr;
					acc_im += xi;
				end
				1:
				begin   // times -j
					acc_re += xi;
					acc_im -= xr;
				end
				2:
				begin
					acc_re -= xr;
					acc_im -= xi;
				end
				default:
				begin   // times j
					acc_re -= xi;
					acc_im += xr;
				end
			endcase
		end
		return make_cplx(acc_re, acc_im);
	endfunction

	task automatic expect_equal(input string name, input int got, input int want);
		checks++;
		if (got != want)
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, want, got);
		end
	endtask

	// holds each sample until in_ready takes it
	task automatic send_frame();
		logic accepted;
		for (int n = 0; n < 4; n++)
		begin
			in_valid <= 1'b1;
			in_sample <= cur_x[n];
			do
			begin
				@(negedge clk);
				accepted = in_ready;
				@(posedge clk);
			end while (!accepted);
		end
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0)
			@(posedge clk);
	endtask

	always @(negedge clk)
	begin
		if (aclr)
			bin_idx = 0;
		else if (out_valid)
		begin
			if (exp_q.size() == 0)
			begin
				errors++;
				$display("output bin at %0t arrived with no frame pending", $time);
			end
			else
			begin
				mon_exp = exp_q.pop_front();
				expect_equal("out_sample.re", int'(out_sample.re), int'(mon_exp.re));
				expect_equal("out_sample.im", int'(out_sample.im), int'(mon_exp.im));
			end
			expect_equal("out_last", int'(out_last), (bin_idx == 3) ? 1 : 0);
			bin_idx = (bin_idx + 1) % 4;
		end
		else if (out_last || bin_idx != 0)
		begin
			errors++;
			$display("output burst broken at %0t after %0d bins", $time, bin_idx);
			bin_idx = 0;
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, output stream stalled", WATCHDOG_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial
	begin
		aclr = 1'b1;
		in_valid = 1'b0;
		in_sample = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		aclr <= 1'b0;
		@(negedge clk);
		expect_equal("out_valid", int'(out_valid), 0);
		expect_equal("in_ready", int'(in_ready), 1);

		// directed frames one at a time
		@(posedge clk);
		for (int f = 0; f < N_DIRECTED; f++)
		begin
			for (int n = 0; n < 4; n++)
			begin
				cur_x[n] = make_cplx(dir_x[f][2*n], dir_x[f][2*n+1]);
				exp_q.push_back(make_cplx(dir_y[f][2*n], dir_y[f][2*n+1]));
			end
			send_frame();
			in_valid <= 1'b0;
			wait_drain();
		end
		@(negedge clk);
		expect_equal("frames_done", int'(frames_done), N_DIRECTED);

		// frame caught mid-pipeline by aclr must never come out
		@(posedge clk);
		send_frame();
		in_valid <= 1'b0;
		repeat (12) @(posedge clk);
		aclr <= 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		aclr <= 1'b0;
		@(negedge clk);
		expect_equal("out_valid", int'(out_valid), 0);
		expect_equal("in_ready", int'(in_ready), 1);
		expect_equal("frames_done", int'(frames_done), 0);

		// random frames back to back with in_valid held high
		@(posedge clk);
		for (int f = 0; f < N_RANDOM; f++)
		begin
			for (int n = 0; n < 4; n++)
			begin
				lcg_state = lcg_next(lcg_state);
				cur_x[n].re = OW'($signed(lcg_state[27:16]));
				lcg_state = lcg_next(lcg_state);
				cur_x[n].im = OW'($signed(lcg_state[27:16]));
			end
			for (int k = 0; k < 4; k++)
				exp_q.push_back(dft_bin(cur_x, k));
			send_frame();
		end
		in_valid <= 1'b0;
		wait_drain();
		@(negedge clk);
		expect_equal("frames_done", int'(frames_done), N_RANDOM);
		repeat (20) @(posedge clk);   // nothing more may come out

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule : fft_pipe_tb

`default_nettype wire

/* fft_pipe.f */
+incdir+logic
logic/fft_pkg.sv
logic/frame_loader.sv
logic/radix2_butterfly.sv
logic/cascade_stage.sv
logic/fft_control.sv
logic/fft_pipe.sv
bench/fft_pipe_tb.sv

/* logic/cascade_stage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fft_settings.svh"

module cascade_stage #(
	parameter int POW = 2   // half span is 2**(POW-1)
) (
	input  wire                 clk,
	input  wire                 aclr,
	input  wire                 up_ready,
	input  wire fft_pkg::cplx_t up_data,
	input  wire fft_pkg::link_t down_link,
	output fft_pkg::link_t      up_link,
	output logic                ready,
	output fft_pkg::cplx_t      data
);

	localparam int WR_DLY = 5;   // memory read plus butterfly

	logic                busy;
	logic [`FFT_POW-1:0] cnt;
	logic                bf_sync;
	logic                bf_tw;
	fft_pkg::cplx_t      bf_y;
	logic [WR_DLY-1:0]   wr_vld;
	logic [`FFT_POW-1:0] wr_cnt [WR_DLY];
	logic                wr_en;
	logic                frame_out;
	logic                rd_done;
	logic                wr_buf;
	logic                rd_buf;
	logic [1:0]          full_cnt;
	fft_pkg::cplx_t      mem [2][`FFT_N];

	// pair order moves the low counter bit up to the span bit
	function automatic logic [`FFT_POW-1:0] pair_order(input logic [`FFT_POW-1:0] c);
		logic [`FFT_POW-1:0] r;
		r = c;
		for (int i = 0; i < POW - 1; i++)
			r[i] = c[i + 1];
		r[POW - 1] = c[0];
		return r;
	endfunction

	always_ff @(posedge clk or posedge aclr)
		if (aclr)
		begin
			busy <= 1'b0;
			cnt  <= '0;
		end
		else if (busy)
		begin
			cnt <= cnt + 1'b1;
			if (&cnt)
				busy <= 1'b0;
		end
		else if (up_ready)
			busy <= 1'b1;

	always_comb
	begin
		up_link.rdaddr = pair_order(cnt);
		up_link.rdack  = busy && (&cnt);
		up_link.rden   = busy;
	end

	// aligned with data coming back from above
	always_ff @(posedge clk or posedge aclr)
		if (aclr)
		begin
			bf_sync <= 1'b0;
			bf_tw   <= 1'b0;
		end
		else
		begin
			bf_sync <= busy && !cnt[0];
			bf_tw   <= busy && cnt[`FFT_POW-1] && (POW == 2);   // second pair only
		end

	radix2_butterfly u_bf (
		.clk     (clk),
		.aclr    (aclr),
		.sync    (bf_sync),
		.twiddle (bf_tw),
		.a       (up_data),
		.y       (bf_y)
	);

	always_ff @(posedge clk or posedge aclr)
		if (aclr)
			wr_vld <= '0;
		else
			wr_vld <= {wr_vld[WR_DLY-2:0], busy};

	always_ff @(posedge clk)
	begin
		wr_cnt[0] <= cnt;
		for (int i = 1; i < WR_DLY; i++)
			wr_cnt[i] <= wr_cnt[i - 1];
	end

	assign wr_en     = wr_vld[WR_DLY-1];
	assign frame_out = wr_en && (&wr_cnt[WR_DLY-1]);
	assign rd_done   = down_link.rdack && ready;
	assign ready     = full_cnt != 2'd0;

	// sum lands on the lower index, difference on the upper
	always_ff @(posedge clk)
		if (wr_en)
			mem[wr_buf][pair_order(wr_cnt[WR_DLY-1])] <= bf_y;

	always_ff @(posedge clk)
		if (down_link.rden)
			data <= mem[rd_buf][down_link.rdaddr];

	always_ff @(posedge clk or posedge aclr)
		if (aclr)
		begin
			wr_buf   <= 1'b0;
			rd_buf   <= 1'b0;
			full_cnt <= 2'd0;
		end
		else
		begin
			if (frame_out)
				wr_buf <= ~wr_buf;
			if (rd_done)
				rd_buf <= ~rd_buf;
			if (frame_out && !rd_done)
				full_cnt <= full_cnt + 2'd1;
			else if (rd_done && !frame_out)
				full_cnt <= full_cnt - 2'd1;
		end

endmodule : cascade_stage

`default_nettype wire

/* logic/fft_control.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fft_settings.svh"

module fft_control (
	input  wire                 clk,
	input  wire                 aclr,
	input  wire                 ready0,
	input  wire                 ready2,
	input  wire fft_pkg::cplx_t data2,
	output fft_pkg::link_t      link2,
	output logic                out_valid,
	output logic                out_last,
	output fft_pkg::cplx_t      out_sample,
	output logic [15:0]         frames_done
);

	logic                busy;
	logic [`FFT_POW-1:0] cnt;
	logic                vld_d;
	logic                last_d;

	function automatic logic [`FFT_POW-1:0] bit_rev(input logic [`FFT_POW-1:0] c);
		logic [`FFT_POW-1:0] r;
		for (int i = 0; i < `FFT_POW; i++)
			r[i] = c[`FFT_POW-1-i];
		return r;
	endfunction

	always_ff @(posedge clk or posedge aclr)
		if (aclr)
		begin
			busy <= 1'b0;
			cnt  <= '0;
		end
		else if (busy)
		begin
			cnt <= cnt + 1'b1;
			if (&cnt)
				busy <= 1'b0;
		end
		else if (ready2)
			busy <= 1'b1;

	always_comb
	begin
		link2.rdaddr = bit_rev(cnt);   // bins leave in natural order
		link2.rdack  = busy && (&cnt);
		link2.rden   = busy;
	end

	always_ff @(posedge clk or posedge aclr)
		if (aclr)
		begin
			vld_d       <= 1'b0;
			last_d      <= 1'b0;
			out_valid   <= 1'b0;
			out_last    <= 1'b0;
			frames_done <= 16'd0;
		end
		else
		begin
			vld_d     <= busy;
			last_d    <= link2.rdack;
			out_valid <= vld_d;
			out_last  <= last_d;
			if (last_d)
				frames_done <= frames_done + 16'd1;
		end

	always_ff @(posedge clk)
		out_sample <= data2;

endmodule : fft_control

`default_nettype wire

/* logic/fft_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module fft_pipe (
	input  wire                 clk,
	input  wire                 aclr,
	input  wire                 in_valid,
	input  wire fft_pkg::cplx_t in_sample,
	output logic                in_ready,
	output logic                out_valid,
	output logic                out_last,
	output fft_pkg::cplx_t      out_sample,
	output logic [15:0]         frames_done
);

	fft_pkg::link_t link0;
	fft_pkg::link_t link1;
	fft_pkg::link_t link2;
	fft_pkg::cplx_t data0;
	fft_pkg::cplx_t data1;
	fft_pkg::cplx_t data2;
	logic           ready0;
	logic           ready1;
	logic           ready2;

	frame_loader u_loader (
		.clk       (clk),
		.aclr      (aclr),
		.in_valid  (in_valid),
		.in_sample (in_sample),
		.link      (link0),
		.in_ready  (in_ready),
		.ready     (ready0),
		.data      (data0)
	);

	// span 2 first with twiddle on the second pair
	cascade_stage #(.POW(2)) u_stage_a (
		.clk       (clk),
		.aclr      (aclr),
		.up_ready  (ready0),
		.up_data   (data0),
		.down_link (link1),
		.up_link   (link0),
		.ready     (ready1),
		.data      (data1)
	);

	cascade_stage #(.POW(1)) u_stage_b (
		.clk       (clk),
		.aclr      (aclr),
		.up_ready  (ready1),
		.up_data   (data1),
		.down_link (link2),
		.up_link   (link1),
		.ready     (ready2),
		.data      (data2)
	);

	fft_control u_control (
		.clk         (clk),
		.aclr        (aclr),
		.ready0      (ready0),
		.ready2      (ready2),
		.data2       (data2),
		.link2       (link2),
		.out_valid   (out_valid),
		.out_last    (out_last),
		.out_sample  (out_sample),
		.frames_done (frames_done)
	);

endmodule : fft_pipe

`default_nettype wire

/* logic/fft_pkg.sv */
`default_nettype none
`include "fft_settings.svh"

package fft_pkg;

	// complex sample carried at the output width through every stage
	typedef struct packed {
		logic signed [`FFT_OUT_W-1:0] re;
		logic signed [`FFT_OUT_W-1:0] im;
	} cplx_t;

	// read request toward the memory of the stage above
	typedef struct packed {
		logic [`FFT_POW-1:0] rdaddr;
		logic                rdack;   // last read of a frame
		logic                rden;    // high while reading
	} link_t;

endpackage : fft_pkg

`default_nettype wire

/* logic/fft_settings.svh */
`ifndef FFT_SETTINGS_SVH
`define FFT_SETTINGS_SVH

// real or imaginary part of a host sample
`define FFT_IN_W 12
// one bit of growth per stage
`define FFT_OUT_W (`FFT_IN_W + 2)

`define FFT_POW 2
`define FFT_N 4

`endif

/* logic/frame_loader.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fft_settings.svh"

module frame_loader (
	input  wire                 clk,
	input  wire                 aclr,
	input  wire                 in_valid,
	input  wire fft_pkg::cplx_t in_sample,
	input  wire fft_pkg::link_t link,
	output logic                in_ready,
	output logic                ready,
	output fft_pkg::cplx_t      data
);

	logic [1:0]          full_cnt;   // frames waiting for stage a
	logic [`FFT_POW-1:0] wr_ptr;
	logic                wr_buf;
	logic                rd_buf;
	logic                accept;
	logic                frame_in;
	logic                rd_done;
	fft_pkg::cplx_t      mem [2][`FFT_N];

	assign in_ready = full_cnt != 2'd2;
	assign ready    = full_cnt != 2'd0;
	assign accept   = in_valid && in_ready;
	assign frame_in = accept && (&wr_ptr);   // fourth sample
	assign rd_done  = link.rdack && ready;

	always_ff @(posedge clk or posedge aclr)
		if (aclr)
		begin
			full_cnt <= 2'd0;
			wr_ptr   <= '0;
			wr_buf   <= 1'b0;
			rd_buf   <= 1'b0;
		end
		else
		begin
			if (accept)
				wr_ptr <= wr_ptr + 1'b1;
			if (frame_in)
				wr_buf <= ~wr_buf;
			if (rd_done)
				rd_buf <= ~rd_buf;
			if (frame_in && !rd_done)
				full_cnt <= full_cnt + 2'd1;
			else if (rd_done && !frame_in)
				full_cnt <= full_cnt - 2'd1;
		end

	always_ff @(posedge clk)
		if (accept)
			mem[wr_buf][wr_ptr] <= in_sample;

	// registered read with data one cycle after rdaddr
	always_ff @(posedge clk)
		if (link.rden)
			data <= mem[rd_buf][link.rdaddr];

endmodule : frame_loader

`default_nettype wire

/* logic/radix2_butterfly.sv */
`timescale 1ns/1ps
`default_nettype none

module radix2_butterfly (
	input  wire                 clk,
	input  wire                 aclr,
	input  wire                 sync,
	input  wire                 twiddle,
	input  wire fft_pkg::cplx_t a,
	output fft_pkg::cplx_t      y
);

	logic [2:0]     sync_d;   // pair phase
	logic           tw_hold;
	logic           tw_s1;
	fft_pkg::cplx_t first;
	fft_pkg::cplx_t sum_s1;
	fft_pkg::cplx_t dif_s1;
	fft_pkg::cplx_t sum_s2;
	fft_pkg::cplx_t dif_s2;

	always_ff @(posedge clk or posedge aclr)
		if (aclr)
			sync_d <= 3'b000;
		else
			sync_d <= {sync_d[1:0], sync};

	always_ff @(posedge clk)
	begin
		if (sync)
		begin
			first   <= a;
			tw_hold <= twiddle;
		end
		if (sync_d[0])   // second sample of the pair
		begin
			sum_s1.re <= first.re + a.re;
			sum_s1.im <= first.im + a.im;
			dif_s1.re <= first.re - a.re;
			dif_s1.im <= first.im - a.im;
			tw_s1     <= tw_hold;
		end
		if (sync_d[1])
		begin
			sum_s2 <= sum_s1;
			if (tw_s1)
			begin
				// times minus j
				dif_s2.re <= dif_s1.im;
				dif_s2.im <= -dif_s1.re;
			end
			else
				dif_s2 <= dif_s1;
		end
		y <= sync_d[2] ? sum_s2 : dif_s2;   // sum first, difference next
	end

endmodule : radix2_butterfly

`default_nettype wire
